// File: logic/alu.sv
`include "rv_defs.svh"

module alu (
  input  rv_pkg::insn_t insn_i,
  input  rv_pkg::word_t op_a_i,
  input  rv_pkg::word_t op_b_i,
  output rv_pkg::word_t result_o
);

  rv_pkg::opcode_t          opcode;
  rv_pkg::funct3_t          funct3;
  rv_pkg::word_t            imm_i;
  rv_pkg::word_t            imm_u;
  rv_pkg::word_t            src_b;
  rv_pkg::word_t            sum;
  logic [$clog2(`XLEN)-1:0] shamt;
  logic                     alt;
  logic                     lt_s;
  logic                     lt_u;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];

  // I and U immediates
  assign imm_i = {{(`XLEN-12){insn_i[31]}}, insn_i[31:20]};
  assign imm_u = {insn_i[31:12], 12'b0};

  // Immediate form replaces rs2
  assign src_b = (opcode == `OP_REG_IMM) ? imm_i : op_b_i;
  assign shamt = src_b[$clog2(`XLEN)-1:0];

  // funct7 bit 5, sub and sra/srai
  assign alt = insn_i[30];

  // No subi, so sub only for register form
  assign sum = (alt && (opcode == `OP_REG_REG)) ? (op_a_i - src_b) : (op_a_i + src_b);

  assign lt_s = $signed(op_a_i) < $signed(src_b);
  assign lt_u = op_a_i < src_b;

  always_comb begin
    case (opcode)
      `OP_REG_IMM, `OP_REG_REG: begin
        case (funct3)
          3'b000: result_o = sum;
          3'b001: result_o = op_a_i << shamt;
          3'b010: result_o = {{(`XLEN-1){1'b0}}, lt_s};
          3'b011: result_o = {{(`XLEN-1){1'b0}}, lt_u};
          3'b100: result_o = op_a_i ^ src_b;
          3'b101: begin
            // Arithmetic or logical right
            if (alt) begin
              result_o = $signed(op_a_i) >>> shamt;
            end else begin
              result_o = op_a_i >> shamt;
            end
          end
          3'b110: result_o = op_a_i | src_b;
          default: result_o = op_a_i & src_b;
        endcase
      end
      `OP_LUI: result_o = imm_u;
      // Branches, ECALL, bubbles
      default: result_o = '0;
    endcase
  end

endmodule

// File: logic/branch_unit.sv
`include "rv_defs.svh"

module branch_unit (
  input  rv_pkg::insn_t insn_i,
  input  rv_pkg::word_t pc_i,
  input  rv_pkg::word_t op_a_i,
  input  rv_pkg::word_t op_b_i,
  output logic          taken_o,
  output rv_pkg::word_t target_o
);

  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  rv_pkg::word_t   imm_b;
  logic            eq;
  logic            lt_s;
  logic            lt_u;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];

  // B immediate, bit 0 always zero
  assign imm_b = {{(`XLEN-12){insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};

  assign target_o = pc_i + imm_b;

  // Shared comparators
  assign eq   = op_a_i == op_b_i;
  assign lt_s = $signed(op_a_i) < $signed(op_b_i);
  assign lt_u = op_a_i < op_b_i;

  always_comb begin
    taken_o = 1'b0;
    if (opcode == `OP_BRANCH) begin
      case (funct3)
        3'b000: taken_o = eq;
        3'b001: taken_o = !eq;
        3'b100: taken_o = lt_s;
        3'b101: taken_o = !lt_s;
        3'b110: taken_o = lt_u;
        3'b111: taken_o = !lt_u;
        // 010 and 011 are reserved
        default: taken_o = 1'b0;
      endcase
    end
  end

endmodule

// File: logic/decode_stage.sv
`include "rv_defs.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_pkg::decode_rec_t  dec_i,
  input  logic                 redirect_i,
  dest_if.consumer             wb,
  output rv_pkg::execute_rec_t exe_o
);

  rv_pkg::opcode_t   opcode;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  logic              writes_reg;
  logic              write_rd;

  // Instruction fields
  assign opcode = dec_i.insn[6:0];
  assign rd     = dec_i.insn[11:7];
  assign rs1    = dec_i.insn[19:15];
  assign rs2    = dec_i.insn[24:20];

  // Opcodes that produce a register value
  always_comb begin
    case (opcode)
      `OP_REG_IMM, `OP_REG_REG, `OP_LUI: writes_reg = 1'b1;
      default: writes_reg = 1'b0;
    endcase
  end

  // Writes to x0 dropped here
  assign write_rd = dec_i.valid && writes_reg && (rd != '0);

  // Writeback port comes in from the top
  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .wb         (wb),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // Bubble on reset or when execute redirects
  always_ff @(posedge clk) begin
    if (rst || redirect_i) begin
      exe_o <= '0;
    end else begin
      exe_o.pc       <= dec_i.pc;
      exe_o.insn     <= dec_i.insn;
      exe_o.rs1_data <= rs1_data;
      exe_o.rs2_data <= rs2_data;
      exe_o.rs1_addr <= rs1;
      exe_o.rs2_addr <= rs2;
      exe_o.rd_addr  <= rd;
      exe_o.write_rd <= write_rd;
      exe_o.valid    <= dec_i.valid;
    end
  end

endmodule

// File: logic/dest_if.sv
// One stage's register write, seen by bypass and register file
interface dest_if;

  // Qualifiers, data only meaningful when both high
  logic valid;
  logic write_rd;

  // Destination and value
  rv_pkg::reg_addr_t rd_addr;
  rv_pkg::word_t     result;

  // Identity of the instruction carrying the write
  rv_pkg::word_t pc;
  rv_pkg::insn_t insn;

  // Stage register side
  modport producer (
    output valid,
    output write_rd,
    output rd_addr,
    output result,
    output pc,
    output insn
  );

  // Bypass mux and register file side
  modport consumer (
    input valid,
    input write_rd,
    input rd_addr,
    input result,
    input pc,
    input insn
  );

endinterface

// File: logic/execute_stage.sv
module execute_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_pkg::execute_rec_t exe_i,
  dest_if.consumer             mem_dest,
  dest_if.consumer             wb_dest,
  output logic                 redirect_o,
  output rv_pkg::word_t        redirect_pc_o,
  output rv_pkg::result_rec_t  mem_o
);

  logic          mem_live;
  logic          wb_live;
  logic          mx_a;
  logic          mx_b;
  logic          wx_a;
  logic          wx_b;
  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_result;
  logic          taken;
  rv_pkg::word_t target;

  // Older stages that will write a register
  assign mem_live = mem_dest.valid && mem_dest.write_rd;
  assign wb_live  = wb_dest.valid && wb_dest.write_rd;

  // Source matches, x0 never forwarded
  assign mx_a = mem_live && (exe_i.rs1_addr != '0) && (mem_dest.rd_addr == exe_i.rs1_addr);
  assign mx_b = mem_live && (exe_i.rs2_addr != '0) && (mem_dest.rd_addr == exe_i.rs2_addr);
  assign wx_a = wb_live && (exe_i.rs1_addr != '0) && (wb_dest.rd_addr == exe_i.rs1_addr);
  assign wx_b = wb_live && (exe_i.rs2_addr != '0) && (wb_dest.rd_addr == exe_i.rs2_addr);

  // Youngest producer first
  always_comb begin
    if (mx_a) begin
      op_a = mem_dest.result;
    end else if (wx_a) begin
      op_a = wb_dest.result;
    end else begin
      op_a = exe_i.rs1_data;
    end
    if (mx_b) begin
      op_b = mem_dest.result;
    end else if (wx_b) begin
      op_b = wb_dest.result;
    end else begin
      op_b = exe_i.rs2_data;
    end
  end

  alu u_alu (
    .insn_i   (exe_i.insn),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .result_o (alu_result)
  );

  branch_unit u_branch_unit (
    .insn_i   (exe_i.insn),
    .pc_i     (exe_i.pc),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .taken_o  (taken),
    .target_o (target)
  );

  // Bubbles never redirect
  assign redirect_o    = exe_i.valid && taken;
  assign redirect_pc_o = target;

  // Branch itself keeps going, only younger stages flush
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_o <= '0;
    end else begin
      mem_o.pc       <= exe_i.pc;
      mem_o.insn     <= exe_i.insn;
      mem_o.result   <= alu_result;
      mem_o.rd_addr  <= exe_i.rd_addr;
      mem_o.write_rd <= exe_i.write_rd;
      mem_o.valid    <= exe_i.valid;
    end
  end

endmodule

// File: logic/fetch_stage.sv
`include "rv_defs.svh"

module fetch_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                redirect_i,
  input  rv_pkg::word_t       redirect_pc_i,
  input  rv_pkg::insn_t       insn_i,
  output rv_pkg::word_t       pc_o,
  output rv_pkg::decode_rec_t dec_o
);

  rv_pkg::word_t pc_q;
  rv_pkg::word_t pc_next;

  // Taken branch wins over sequential step
  assign pc_next = redirect_i ? redirect_pc_i : (pc_q + `INSN_STEP);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Memory answers in the same cycle
  assign pc_o = pc_q;

  // Word fetched this cycle is wrong path on a redirect
  always_ff @(posedge clk) begin
    if (rst || redirect_i) begin
      dec_o <= '0;
    end else begin
      dec_o.pc    <= pc_q;
      dec_o.insn  <= insn_i;
      dec_o.valid <= 1'b1;
    end
  end

endmodule

// File: logic/reg_file.sv
`include "rv_defs.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst,
  dest_if.consumer          wb,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o
);

  rv_pkg::word_t regs [`NUM_REGS];
  logic          we;

  // x0 never written
  assign we = wb.valid && wb.write_rd && (wb.rd_addr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wb.rd_addr] <= wb.result;
    end
  end

  // Read ports, write-through when writeback hits the same index
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (we && (wb.rd_addr == rs1_i)) begin
      rs1_data_o = wb.result;
    end else begin
      rs1_data_o = regs[rs1_i];
    end
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else if (we && (wb.rd_addr == rs2_i)) begin
      rs2_data_o = wb.result;
    end else begin
      rs2_data_o = regs[rs2_i];
    end
  end

endmodule

// File: logic/rv_core.sv
`include "rv_defs.svh"

module rv_core (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     pc_o,
  input  rv_pkg::insn_t     insn_i,
  output logic              halt_o,
  output logic              trace_valid_o,
  output rv_pkg::word_t     trace_pc_o,
  output rv_pkg::insn_t     trace_insn_o,
  output logic              trace_write_o,
  output rv_pkg::reg_addr_t trace_rd_o,
  output rv_pkg::word_t     trace_result_o
);

  logic                 redirect;
  rv_pkg::word_t        redirect_pc;
  rv_pkg::decode_rec_t  dec_q;
  rv_pkg::execute_rec_t exe_q;
  rv_pkg::result_rec_t  mem_q;
  rv_pkg::result_rec_t  wb_q;

  dest_if mem_dest ();
  dest_if wb_dest ();

  fetch_stage u_fetch (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .insn_i        (insn_i),
    .pc_o          (pc_o),
    .dec_o         (dec_q)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .dec_i      (dec_q),
    .redirect_i (redirect),
    .wb         (wb_dest),
    .exe_o      (exe_q)
  );

  execute_stage u_execute (
    .clk           (clk),
    .rst           (rst),
    .exe_i         (exe_q),
    .mem_dest      (mem_dest),
    .wb_dest       (wb_dest),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .mem_o         (mem_q)
  );

  // No data memory, memory stage just passes the record on
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= '0;
    end else begin
      wb_q <= mem_q;
    end
  end

  // Memory stage write for MX bypass
  assign mem_dest.valid    = mem_q.valid;
  assign mem_dest.write_rd = mem_q.write_rd;
  assign mem_dest.rd_addr  = mem_q.rd_addr;
  assign mem_dest.result   = mem_q.result;
  assign mem_dest.pc       = mem_q.pc;
  assign mem_dest.insn     = mem_q.insn;

  // Writeback write, register file and WX bypass
  assign wb_dest.valid    = wb_q.valid;
  assign wb_dest.write_rd = wb_q.write_rd;
  assign wb_dest.rd_addr  = wb_q.rd_addr;
  assign wb_dest.result   = wb_q.result;
  assign wb_dest.pc       = wb_q.pc;
  assign wb_dest.insn     = wb_q.insn;

  // ECALL retiring
  assign halt_o = wb_dest.valid && (wb_dest.insn[6:0] == `OP_SYSTEM);

  // Bubbles carry all-zero records, so trace is zero too
  assign trace_valid_o  = wb_dest.valid;
  assign trace_pc_o     = wb_dest.pc;
  assign trace_insn_o   = wb_dest.insn;
  assign trace_write_o  = wb_dest.write_rd;
  assign trace_rd_o     = wb_dest.rd_addr;
  assign trace_result_o = wb_dest.result;

endmodule

// File: logic/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Architectural register width
`define XLEN 32

// Integer register count, x0 included
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Sequential pc increment
`define INSN_STEP 32'd4

// Major opcodes kept by this core
`define OP_REG_IMM 7'b0010011
`define OP_REG_REG 7'b0110011
`define OP_LUI     7'b0110111
`define OP_BRANCH  7'b1100011
// ECALL lives here
`define OP_SYSTEM  7'b1110011

`endif

// File: logic/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

  // Data and pc values
  typedef logic [`XLEN-1:0] word_t;

  // RV32I encodings are always 32 bits
  typedef logic [31:0] insn_t;

  // Register index
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

  // Minor and major opcode fields
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] opcode_t;

  // Fetch to decode
  typedef struct packed {
    word_t pc;
    insn_t insn;
    logic  valid;
  } decode_rec_t;

  // Decode to execute
  typedef struct packed {
    word_t     pc;
    insn_t     insn;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      write_rd;
    logic      valid;
  } execute_rec_t;

  // Execute to memory, memory to writeback
  typedef struct packed {
    word_t     pc;
    insn_t     insn;
    word_t     result;
    reg_addr_t rd_addr;
    logic      write_rd;
    logic      valid;
  } result_rec_t;

endpackage

// File: project.f
+incdir+logic
+incdir+testbench
logic/rv_pkg.sv
logic/dest_if.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/alu.sv
logic/branch_unit.sv
logic/execute_stage.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module tb_rv_core -o sim_rv_core \
  && ./obj_dir/sim_rv_core | tee /dev/stderr | grep -q "TESTS PASSED" \
  || { echo "simulation did not pass"; exit 1; }

// File: testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Register value expected once the program halts
task automatic expect_final(input int rd, input rv_pkg::word_t value);
  fin_rd.push_back(rd);
  fin_val.push_back(value);
endtask

// ALU ops, LUI, x0 destination, bypass distances 1 to 3
task automatic load_alu_program;
  prog.delete();
  fin_rd.delete();
  fin_val.delete();
  prog.push_back(enc_i(5, 0, 0, 1));
  prog.push_back(enc_i(7, 1, 0, 2));
  prog.push_back(enc_r(0, 2, 1, 0, 3));
  prog.push_back(enc_r(32, 1, 3, 0, 4));
  prog.push_back(enc_lui(32'h80000, 5));
  prog.push_back(enc_i(1024 + 4, 5, 5, 6));
  prog.push_back(enc_i(4, 5, 5, 7));
  prog.push_back(enc_r(0, 1, 6, 2, 8));
  prog.push_back(enc_r(0, 1, 6, 3, 9));
  prog.push_back(enc_i(-1, 1, 4, 10));
  prog.push_back(enc_r(0, 2, 1, 6, 11));
  prog.push_back(enc_r(0, 2, 1, 7, 12));
  prog.push_back(enc_r(0, 2, 1, 1, 13));
  // Write to x0 must vanish
  prog.push_back(enc_i(9, 1, 0, 0));
  prog.push_back(enc_r(0, 1, 0, 0, 14));
  prog.push_back(enc_i(3, 1, 1, 15));
  prog.push_back(enc_i(6, 1, 3, 16));
  prog.push_back(ECALL);
  expect_final(1, 32'd5);
  expect_final(2, 32'd12);
  expect_final(3, 32'd17);
  expect_final(4, 32'd12);
  expect_final(5, 32'h8000_0000);
  expect_final(6, 32'hF800_0000);
  expect_final(7, 32'h0800_0000);
  expect_final(8, 32'd1);
  expect_final(9, 32'd0);
  expect_final(10, 32'hFFFF_FFFA);
  expect_final(11, 32'd13);
  expect_final(12, 32'd4);
  expect_final(13, 32'h0000_5000);
  expect_final(14, 32'd5);
  expect_final(15, 32'd40);
  expect_final(16, 32'd1);
endtask

// All six conditions, taken and not taken, plus a short loop
task automatic load_branch_program;
  prog.delete();
  fin_rd.delete();
  fin_val.delete();
  prog.push_back(enc_i(3, 0, 0, 1));
  prog.push_back(enc_i(3, 0, 0, 2));
  prog.push_back(enc_b(12, 2, 1, 0));
  prog.push_back(enc_i(1, 0, 0, 3));
  prog.push_back(enc_i(2, 0, 0, 3));
  prog.push_back(enc_b(8, 2, 1, 1));
  prog.push_back(enc_i(-2, 0, 0, 4));
  prog.push_back(enc_b(8, 1, 4, 4));
  prog.push_back(enc_i(9, 0, 0, 5));
  prog.push_back(enc_b(8, 1, 4, 6));
  prog.push_back(enc_i(7, 0, 0, 6));
  prog.push_back(enc_b(8, 1, 6, 5));
  prog.push_back(enc_i(1, 0, 0, 7));
  prog.push_back(enc_b(8, 6, 1, 7));
  // Loop counts x1 down, branch reads it at distance 1
  prog.push_back(enc_i(-1, 1, 0, 1));
  prog.push_back(enc_b(-4, 0, 1, 1));
  prog.push_back(ECALL);
  expect_final(1, 32'd0);
  expect_final(2, 32'd3);
  expect_final(3, 32'd0);
  expect_final(4, 32'hFFFF_FFFE);
  expect_final(5, 32'd0);
  expect_final(6, 32'd7);
  expect_final(7, 32'd0);
endtask

`endif

// File: testbench/tb_rv_core.sv
`include "rv_defs.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEED = 79239;
  localparam int RAND_LEN = 24;
  localparam int MEM_WORDS = 256;
  localparam rv_pkg::insn_t ECALL = 32'h0000_0073;

  logic              clk;
  logic              rst;
  rv_pkg::word_t     pc_o;
  rv_pkg::insn_t     insn_i;
  logic              halt_o;
  logic              trace_valid_o;
  rv_pkg::word_t     trace_pc_o;
  rv_pkg::insn_t     trace_insn_o;
  logic              trace_write_o;
  rv_pkg::reg_addr_t trace_rd_o;
  rv_pkg::word_t     trace_result_o;

  // Program, instruction memory and expected retirements
  rv_pkg::insn_t imem [MEM_WORDS];
  rv_pkg::insn_t prog[$];
  int            fin_rd[$];
  rv_pkg::word_t fin_val[$];
  rv_pkg::word_t exp_pc[$];
  rv_pkg::insn_t exp_insn[$];
  rv_pkg::word_t exp_res[$];
  logic          exp_wr[$];
  logic          exp_halt[$];
  int            exp_rd[$];
  rv_pkg::word_t model_regs [32];
  rv_pkg::word_t seen_regs [32];

  string test_name = "reset";
  int    seed;
  int    err_value = 0;
  int    err_other = 0;
  int    rst_cycles = 0;
  int    since_rst = 0;
  logic  running = 1'b0;
  logic  halt_seen = 1'b0;
  logic  timed_out = 1'b0;

  rv_core dut (
    .clk            (clk),
    .rst            (rst),
    .pc_o           (pc_o),
    .insn_i         (insn_i),
    .halt_o         (halt_o),
    .trace_valid_o  (trace_valid_o),
    .trace_pc_o     (trace_pc_o),
    .trace_insn_o   (trace_insn_o),
    .trace_write_o  (trace_write_o),
    .trace_rd_o     (trace_rd_o),
    .trace_result_o (trace_result_o)
  );

  always #50 clk = ~clk;

  // Instruction memory, word returned for the pc of this cycle
  always @(posedge clk) begin
    #1;
    insn_i = imem[pc_o[9:2]];
  end

  // Instruction encoders per the RV32I formats
  function automatic rv_pkg::insn_t enc_i(int imm, int rs1, int f3, int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `OP_REG_IMM};
  endfunction

  function automatic rv_pkg::insn_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_REG_REG};
  endfunction

  function automatic rv_pkg::insn_t enc_lui(int imm, int rd);
    return {imm[19:0], rd[4:0], `OP_LUI};
  endfunction

  function automatic rv_pkg::insn_t enc_b(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], `OP_BRANCH};
  endfunction

  `include "tb_programs.svh"

  // Dependent ALU ops over x0..x7, so most sources hit a recent write
  task automatic build_random_program;
    int r;
    int rd;
    int rs1;
    int rs2;
    int imm;
    prog.delete();
    fin_rd.delete();
    fin_val.delete();
    for (int n = 0; n < RAND_LEN; n++) begin
      r   = $random(seed);
      rd  = 1 + (r & 7) % 7;
      rs1 = (r >> 3) & 7;
      rs2 = (r >> 6) & 7;
      imm = (r >> 9) & 12'hFFF;
      case (((r >> 21) & 15) % 10)
        0: prog.push_back(enc_i(imm, rs1, 0, rd));
        1: prog.push_back(enc_r(0, rs2, rs1, 0, rd));
        2: prog.push_back(enc_r(32, rs2, rs1, 0, rd));
        3: prog.push_back(enc_i(imm & 31, rs1, 1, rd));
        4: prog.push_back(enc_i((imm & 31) | 1024, rs1, 5, rd));
        5: prog.push_back(enc_r(0, rs2, rs1, 5, rd));
        6: prog.push_back(enc_r(0, rs2, rs1, 2, rd));
        7: prog.push_back(enc_i(imm, rs1, 3, rd));
        8: prog.push_back(enc_r(0, rs2, rs1, 4, rd));
        default: prog.push_back(enc_lui(r >> 12, rd));
      endcase
    end
    prog.push_back(ECALL);
  endtask

  // Reference ALU, straight from the ISA semantics
  function automatic rv_pkg::word_t alu_ref(rv_pkg::insn_t w, rv_pkg::word_t a, rv_pkg::word_t b);
    rv_pkg::word_t y;
    logic [4:0]    sh;
    if (w[6:0] == `OP_LUI) begin
      return {w[31:12], 12'b0};
    end
    y  = (w[6:0] == `OP_REG_IMM) ? {{20{w[31]}}, w[31:20]} : b;
    sh = y[4:0];
    case (w[14:12])
      3'd0: return (w[6:0] == `OP_REG_REG && w[30]) ? a - y : a + y;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: return (a < y) ? 32'd1 : 32'd0;
      3'd4: return a ^ y;
      3'd5: return w[30] ? rv_pkg::word_t'($signed(a) >>> sh) : a >> sh;
      3'd6: return a | y;
      default: return a & y;
    endcase
  endfunction

  function automatic logic branch_ref(rv_pkg::insn_t w, rv_pkg::word_t a, rv_pkg::word_t b);
    case (w[14:12])
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Run the program in order and queue every retirement up to ECALL
  task automatic run_model;
    rv_pkg::word_t pc;
    rv_pkg::insn_t w;
    rv_pkg::word_t r;
    logic          wr;
    exp_pc.delete();
    exp_insn.delete();
    exp_res.delete();
    exp_wr.delete();
    exp_halt.delete();
    exp_rd.delete();
    foreach (model_regs[i]) model_regs[i] = '0;
    pc = `RESET_PC;
    for (int n = 0; n < 1000; n++) begin
      w = imem[pc[9:2]];
      exp_pc.push_back(pc);
      exp_insn.push_back(w);
      exp_halt.push_back(w == ECALL);
      exp_rd.push_back(int'(w[11:7]));
      r  = '0;
      wr = 1'b0;
      if (w[6:0] == `OP_BRANCH) begin
        if (branch_ref(w, model_regs[w[19:15]], model_regs[w[24:20]])) begin
          pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else begin
          pc = pc + 32'd4;
        end
      end else if (w != ECALL) begin
        r  = alu_ref(w, model_regs[w[19:15]], model_regs[w[24:20]]);
        wr = (w[11:7] != 5'd0);
        if (wr) model_regs[w[11:7]] = r;
        pc = pc + 32'd4;
      end
      exp_res.push_back(r);
      exp_wr.push_back(wr);
      if (w == ECALL) break;
    end
  endtask

  task automatic check_value(string what, rv_pkg::word_t expected, rv_pkg::word_t actual);
    assert (actual === expected) else begin
      err_value++;
      $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  // Trace compare at mid cycle, away from the edge
  always @(negedge clk) begin
    logic eh;
    logic ew;
    int   erd;
    if (running && trace_valid_o) begin
      if (exp_pc.size() == 0) begin
        err_other++;
        $display("%s: instruction at pc %h retired past the end of the program",
                 test_name, trace_pc_o);
      end else begin
        eh  = exp_halt.pop_front();
        ew  = exp_wr.pop_front();
        erd = exp_rd.pop_front();
        check_value("pc", exp_pc.pop_front(), trace_pc_o);
        check_value("insn", exp_insn.pop_front(), trace_insn_o);
        check_value("write", {31'b0, ew}, {31'b0, trace_write_o});
        check_value("halt", {31'b0, eh}, {31'b0, halt_o});
        if (ew) begin
          check_value("rd", erd, {27'b0, trace_rd_o});
          check_value("result", exp_res.pop_front(), trace_result_o);
        end else begin
          void'(exp_res.pop_front());
        end
        if (trace_write_o) seen_regs[trace_rd_o] = trace_result_o;
        if (halt_o) halt_seen = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      rst_cycles <= rst_cycles + 1;
      since_rst  <= 0;
    end else begin
      rst_cycles <= 0;
      since_rst  <= since_rst + 1;
    end
  end

  // First edge of reset still sees the old pc
  assert property (@(posedge clk) (rst && rst_cycles > 0) |->
                   (pc_o == `RESET_PC && !trace_valid_o && !halt_o))
    else begin
      err_other++;
      $display("%s: pc, trace or halt not cleared during reset", test_name);
    end

  // Pipeline still filling
  assert property (@(posedge clk) (!rst && since_rst < 4) |-> (!trace_valid_o && !halt_o))
    else begin
      err_other++;
      $display("%s: retirement or halt within 4 cycles of reset", test_name);
    end

  task automatic run_program(string name);
    int limit;
    int cycles;
    test_name = name;
    // Fill is addi x0,x0,index
    for (int i = 0; i < MEM_WORDS; i++) imem[i] = enc_i(i, 0, 0, 0);
    foreach (prog[i]) imem[i] = prog[i];
    run_model();
    foreach (seen_regs[i]) seen_regs[i] = '0;
    halt_seen = 1'b0;
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst     = 1'b0;
    running = 1'b1;
    limit   = prog.size() * 3 + 50;
    cycles  = 0;
    while (!halt_seen && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    running = 1'b0;
    if (!halt_seen) begin
      err_other++;
      timed_out = 1'b1;
      $display("%s: timeout, no halt after %0d cycles", name, limit);
    end else begin
      if (exp_pc.size() != 0) begin
        err_other++;
        $display("%s: %0d expected retirements never appeared", name, exp_pc.size());
      end
      for (int r = 1; r < 32; r++) begin
        check_value($sformatf("model x%0d", r), model_regs[r], seen_regs[r]);
      end
      foreach (fin_rd[i]) begin
        check_value($sformatf("final x%0d", fin_rd[i]), fin_val[i], seen_regs[fin_rd[i]]);
      end
    end
  endtask

  initial begin
    clk    = 1'b0;
    rst    = 1'b1;
    insn_i = '0;
    seed   = SEED;
    load_alu_program();
    run_program("alu_bypass");
    if (!timed_out) begin
      load_branch_program();
      run_program("branches");
    end
    if (!timed_out) begin
      build_random_program();
      run_program("random_alu");
    end
    $display("Errors: value %0d, other %0d", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
